// File: filelist.f
+incdir+.
mcu_cmd_pkg.sv
config_regs.sv
mem_access_ctrl.sv
spi_readback.sv
mcu_cmd_top.sv
mcu_cmd_asserts.sv
tb_mcu_cmd.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_mcu_cmd
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = >>> PASS

SOURCES = $(wildcard *.sv *.svh)
BINARY  = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(BINARY)
	@out="$$(./$(BINARY))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: tb_mcu_cmd.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_macros.svh"

module tb_mcu_cmd;

  localparam int TIMEOUT_CYCLES = 50;
  localparam int MARGIN_CYCLES  = 5;

  // row kinds
  localparam logic [1:0] S_NONE  = 2'd0;
  localparam logic [1:0] S_CMD   = 2'd1;
  localparam logic [1:0] S_PARAM = 2'd2;
  localparam logic [1:0] S_WAIT  = 2'd3;

  // check kinds
  localparam logic [2:0] C_NONE  = 3'd0;
  localparam logic [2:0] C_CFG   = 3'd1;
  localparam logic [2:0] C_REQ   = 3'd2;
  localparam logic [2:0] C_BYTE  = 3'd3;
  localparam logic [2:0] C_RDATA = 3'd4;

  logic              clk;
  logic              rst;
  logic              cmd_ready;
  logic              param_ready;
  logic [`CMD_W-1:0] cmd_data;
  byte               param_data;
  logic [`CNT_W-1:0] spi_byte_cnt;
  logic              mcu_rq_rdy;
  byte               mcu_data_in;

  mcu_cmd_pkg::cfg_t     cfg;
  mcu_cmd_pkg::mem_req_t mem_req;
  byte                   spi_data_out;

  // responder bookkeeping
  int  done_cnt;
  int  seen_cnt;
  byte last_rdata;

  // stimulus table
  string       row_name  [$];
  logic [1:0]  row_kind  [$];
  logic [7:0]  row_cmd   [$];
  logic [7:0]  row_param [$];
  logic [7:0]  row_cnt   [$];
  logic [2:0]  row_check [$];
  logic [67:0] row_exp   [$];

  mcu_cmd_top uut (
    .clk          (clk),
    .rst          (rst),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .spi_byte_cnt (spi_byte_cnt),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_data_in  (mcu_data_in),
    .cfg          (cfg),
    .mem_req      (mem_req),
    .spi_data_out (spi_data_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_cfg(input string name, input mcu_cmd_pkg::cfg_t want,
                           input mcu_cmd_pkg::cfg_t got);
    if (got !== want) begin
      stop_run($sformatf("mismatch in %s expected %h actual %h", name, want, got));
    end
  endtask

  task automatic check_req(input string name, input mcu_cmd_pkg::mem_req_t want,
                           input mcu_cmd_pkg::mem_req_t got);
    if (got !== want) begin
      stop_run($sformatf("mismatch in %s expected %h actual %h", name, want, got));
    end
  endtask

  task automatic check_byte(input string name, input byte want, input byte got);
    if (got !== want) begin
      stop_run($sformatf("mismatch in %s expected %h actual %h", name, want, got));
    end
  endtask

  task automatic add_row(input string name, input logic [1:0] kind, input logic [7:0] cmd,
                         input logic [7:0] param, input logic [7:0] cnt,
                         input logic [2:0] check, input logic [67:0] want);
    row_name.push_back(name);
    row_kind.push_back(kind);
    row_cmd.push_back(cmd);
    row_param.push_back(param);
    row_cnt.push_back(cnt);
    row_check.push_back(check);
    row_exp.push_back(want);
  endtask

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  task automatic build_table();
    mcu_cmd_pkg::cfg_t     ec;
    mcu_cmd_pkg::mem_req_t er;
    ec = '0;
    ec.mapper = 3'd1;
    er = '0;
    add_row("reset cfg", S_NONE, 8'h00, 8'h00, 8'd0, C_CFG, 68'(ec));
    add_row("reset req", S_NONE, 8'h00, 8'h00, 8'd0, C_REQ, 68'(er));
    add_row("reset spi", S_NONE, 8'h00, 8'h00, 8'd0, C_BYTE, 68'(8'h00));
    ec.mapper = 3'd5;
    add_row("mapper 35", S_CMD, 8'h35, 8'h00, 8'd1, C_CFG, 68'(ec));
    ec.mapper = 3'd2;
    add_row("mapper 3a", S_CMD, 8'h3A, 8'h00, 8'd1, C_CFG, 68'(ec));
    // rom mask, high byte first
    add_row("rom mask cmd", S_CMD, 8'h10, 8'h00, 8'd1, C_CFG, 68'(ec));
    ec.rom_mask = 24'h3F0000;
    add_row("rom mask b2", S_PARAM, 8'h10, 8'h3F, 8'd2, C_CFG, 68'(ec));
    ec.rom_mask = 24'h3FFF00;
    add_row("rom mask b3", S_PARAM, 8'h10, 8'hFF, 8'd3, C_CFG, 68'(ec));
    ec.rom_mask = 24'h3FFF80;
    add_row("rom mask b4", S_PARAM, 8'h10, 8'h80, 8'd4, C_CFG, 68'(ec));
    add_row("sram mask cmd", S_CMD, 8'h20, 8'h00, 8'd1, C_NONE, 68'd0);
    add_row("sram mask b2", S_PARAM, 8'h20, 8'h01, 8'd2, C_NONE, 68'd0);
    add_row("sram mask b3", S_PARAM, 8'h20, 8'hE0, 8'd3, C_NONE, 68'd0);
    ec.saveram_mask = 24'h01E007;
    add_row("sram mask b4", S_PARAM, 8'h20, 8'h07, 8'd4, C_CFG, 68'(ec));
    // feature word stays put until its second byte
    add_row("feat cmd", S_CMD, 8'hED, 8'h00, 8'd1, C_NONE, 68'd0);
    add_row("feat b2 staged", S_PARAM, 8'hED, 8'h12, 8'd2, C_CFG, 68'(ec));
    ec.featurebits = 16'h1234;
    add_row("feat b3", S_PARAM, 8'hED, 8'h34, 8'd3, C_CFG, 68'(ec));
    add_row("region cmd", S_CMD, 8'hEE, 8'h00, 8'd1, C_NONE, 68'd0);
    ec.region = 1'b1;
    add_row("region b2", S_PARAM, 8'hEE, 8'h01, 8'd2, C_CFG, 68'(ec));

    //////////////////////////////
    // address pointer
    //////////////////////////////
    add_row("addr cmd", S_CMD, 8'h00, 8'h00, 8'd1, C_REQ, 68'(er));
    er.addr = 24'h120000;
    add_row("addr b2", S_PARAM, 8'h00, 8'h12, 8'd2, C_REQ, 68'(er));
    er.addr = 24'h123400;
    add_row("addr b3", S_PARAM, 8'h00, 8'h34, 8'd3, C_REQ, 68'(er));
    er.addr = 24'h123456;
    add_row("addr b4", S_PARAM, 8'h00, 8'h56, 8'd4, C_REQ, 68'(er));
    add_row("addr2 cmd", S_CMD, 8'h00, 8'h00, 8'd1, C_NONE, 68'd0);
    er.addr = 24'h7F0000;
    add_row("addr2 b2 clears low", S_PARAM, 8'h00, 8'h7F, 8'd2, C_REQ, 68'(er));
    add_row("addr2 b3", S_PARAM, 8'h00, 8'hFF, 8'd3, C_NONE, 68'd0);
    er.addr = 24'h7FFFFF;
    add_row("addr2 b4", S_PARAM, 8'h00, 8'hFF, 8'd4, C_REQ, 68'(er));

    //////////////////////////////
    // memory access
    //////////////////////////////
    er.rrq = 1'b1;
    add_row("read 88 rrq", S_CMD, 8'h88, 8'h00, 8'd1, C_REQ, 68'(er));
    add_row("read 88 data", S_WAIT, 8'h88, 8'h00, 8'd1, C_RDATA, 68'd0);
    er.rrq  = 1'b0;
    er.addr = 24'h800000;
    add_row("read 88 addr inc", S_NONE, 8'h88, 8'h00, 8'd1, C_REQ, 68'(er));
    er.rrq = 1'b1;
    add_row("read 80 rrq", S_CMD, 8'h80, 8'h00, 8'd1, C_REQ, 68'(er));
    add_row("read 80 data", S_WAIT, 8'h80, 8'h00, 8'd1, C_RDATA, 68'd0);
    er.rrq = 1'b0;
    add_row("read 80 addr held", S_NONE, 8'h80, 8'h00, 8'd1, C_REQ, 68'(er));
    add_row("write 98 cmd", S_CMD, 8'h98, 8'h00, 8'd1, C_REQ, 68'(er));
    er.wrq   = 1'b1;
    er.wdata = 8'hC3;
    add_row("write 98 wrq", S_PARAM, 8'h98, 8'hC3, 8'd2, C_REQ, 68'(er));
    er.wrq  = 1'b0;
    er.addr = 24'h800001;
    add_row("write 98 addr inc", S_WAIT, 8'h98, 8'hC3, 8'd2, C_REQ, 68'(er));

    // readback byte
    add_row("id f0", S_CMD, 8'hF0, 8'h00, 8'd1, C_BYTE, 68'(8'hA5));
    add_row("echo cmd", S_CMD, 8'hFF, 8'h00, 8'd1, C_NONE, 68'd0);
    add_row("echo b2", S_PARAM, 8'hFF, 8'h3C, 8'd2, C_BYTE, 68'(8'h3C));
    add_row("final cfg", S_NONE, 8'hFF, 8'h00, 8'd2, C_CFG, 68'(ec));
  endtask

  task automatic wait_mem_done(input string name);
    int cycles;
    cycles = 0;
    while (done_cnt == seen_cnt && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (done_cnt == seen_cnt) begin
      stop_run($sformatf("timeout waiting for memory completion in %s", name));
    end else begin
      seen_cnt = done_cnt;
      // let next_addr and the address update settle
      repeat (MARGIN_CYCLES) @(negedge clk);
    end
  endtask

  task automatic check_row(input int i);
    logic [67:0] want;
    want = row_exp[i];
    case (row_check[i])
      C_CFG:   check_cfg(row_name[i], mcu_cmd_pkg::cfg_t'(want), cfg);
      C_REQ:   check_req(row_name[i], mcu_cmd_pkg::mem_req_t'(want[33:0]), mem_req);
      C_BYTE:  check_byte(row_name[i], want[7:0], spi_data_out);
      C_RDATA: check_byte(row_name[i], last_rdata, spi_data_out);
      default: ;
    endcase
  endtask

  task automatic apply_row(input int i);
    @(negedge clk);
    cmd_data     = row_cmd[i];
    param_data   = row_param[i];
    spi_byte_cnt = row_cnt[i];
    cmd_ready    = row_kind[i] == S_CMD;
    param_ready  = row_kind[i] == S_PARAM;
    if (row_kind[i] == S_WAIT) begin
      wait_mem_done(row_name[i]);
    end else begin
      @(negedge clk);
      cmd_ready   = 1'b0;
      param_ready = 1'b0;
    end
    check_row(i);
  endtask

  //////////////////////////////
  // memory responder
  //////////////////////////////

  initial begin
    int delay;
    void'($urandom(36));
    forever begin
      @(negedge clk);
      if (mem_req.rrq || mem_req.wrq) begin
        delay = 1 + int'($urandom % 6);
        repeat (delay) @(negedge clk);
        mcu_data_in = 8'($urandom);
        last_rdata  = mcu_data_in;
        mcu_rq_rdy  = 1'b1;
        done_cnt++;
        repeat (3) @(negedge clk);
        mcu_rq_rdy = 1'b0;
      end
    end
  end

  initial begin
    #(20 * 5000);
    stop_run("watchdog expired, simulation ran too long");
  end

  initial begin
    rst          = 1'b1;
    cmd_ready    = 1'b0;
    param_ready  = 1'b0;
    cmd_data     = '0;
    param_data   = '0;
    spi_byte_cnt = '0;
    mcu_rq_rdy   = 1'b0;
    mcu_data_in  = '0;
    last_rdata   = '0;
    done_cnt     = 0;
    seen_cnt     = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    build_table();
    for (int i = 0; i < row_name.size(); i++) begin
      apply_row(i);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: mcu_cmd_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_cmd_asserts (
  input logic                  clk,
  input logic                  rst,
  input logic                  mcu_rq_rdy,
  input mcu_cmd_pkg::mem_req_t mem_req,
  input logic                  next_addr
);

  // only one request kind per cycle
  a_req_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(mem_req.rrq && mem_req.wrq))
    else $error("rrq and wrq are high in the same cycle");

  // requests are single-cycle pulses
  a_rrq_pulse: assert property (@(posedge clk) disable iff (rst)
    mem_req.rrq |=> !mem_req.rrq)
    else $error("rrq stayed high for more than one cycle");

  a_wrq_pulse: assert property (@(posedge clk) disable iff (rst)
    mem_req.wrq |=> !mem_req.wrq)
    else $error("wrq stayed high for more than one cycle");

  // completion pulse two cycles after the ready edge
  a_next_addr_after_rdy: assert property (@(posedge clk) disable iff (rst)
    $rose(mcu_rq_rdy) |-> ##2 next_addr)
    else $error("next_addr missing two cycles after mcu_rq_rdy rose");

  a_next_addr_cause: assert property (@(posedge clk) disable iff (rst)
    next_addr |-> $past(mcu_rq_rdy, 2) && !$past(mcu_rq_rdy, 3))
    else $error("next_addr without a ready edge two cycles before");

endmodule

bind mcu_cmd_top mcu_cmd_asserts u_asserts (
  .clk        (clk),
  .rst        (rst),
  .mcu_rq_rdy (mcu_rq_rdy),
  .mem_req    (mem_req),
  .next_addr  (next_addr)
);

`default_nettype wire

// File: mcu_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_macros.svh"

module mcu_cmd_top (
  input  logic                  clk,
  input  logic                  rst,

  // SPI front end
  input  logic                  cmd_ready,
  input  logic                  param_ready,
  input  logic [`CMD_W-1:0]     cmd_data,
  input  byte                   param_data,
  input  logic [`CNT_W-1:0]     spi_byte_cnt,

  // memory arbiter
  input  logic                  mcu_rq_rdy,
  input  byte                   mcu_data_in,

  output mcu_cmd_pkg::cfg_t     cfg,
  output mcu_cmd_pkg::mem_req_t mem_req,
  output byte                   spi_data_out
);

  mcu_cmd_pkg::spi_evt_t evt;
  logic                  next_addr;

  // one event bundle for all units
  assign evt.cmd_ready   = cmd_ready;
  assign evt.param_ready = param_ready;
  assign evt.cmd.raw     = cmd_data;
  assign evt.param       = param_data;
  assign evt.byte_cnt    = spi_byte_cnt;

  config_regs u_config_regs (
    .clk (clk),
    .rst (rst),
    .evt (evt),
    .cfg (cfg)
  );

  mem_access_ctrl u_mem_access_ctrl (
    .clk        (clk),
    .rst        (rst),
    .evt        (evt),
    .mcu_rq_rdy (mcu_rq_rdy),
    .mem_req    (mem_req),
    .next_addr  (next_addr)
  );

  spi_readback u_spi_readback (
    .clk          (clk),
    .rst          (rst),
    .evt          (evt),
    .next_addr    (next_addr),
    .mcu_data_in  (mcu_data_in),
    .spi_data_out (spi_data_out)
  );

endmodule

`default_nettype wire

// File: spi_readback.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_macros.svh"

module spi_readback (
  input  logic                  clk,
  input  logic                  rst,
  input  mcu_cmd_pkg::spi_evt_t evt,
  input  logic                  next_addr,
  input  byte                   mcu_data_in,
  output byte                   spi_data_out
);

  logic strobe;

  assign strobe = evt.cmd_ready | evt.param_ready;

  //////////////////////////////
  // readback byte
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      spi_data_out <= '0;
    end else if (next_addr && evt.cmd.nib.op == `OP_READ) begin
      // memory read finished, hand the data to the mcu
      spi_data_out <= mcu_data_in;
    end else if (strobe) begin
      case (evt.cmd.raw)
        `CMD_ID:   spi_data_out <= `ID_BYTE;
        `CMD_ECHO: spi_data_out <= evt.param;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: mem_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_macros.svh"

module mem_access_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  mcu_cmd_pkg::spi_evt_t evt,
  input  logic                  mcu_rq_rdy,
  output mcu_cmd_pkg::mem_req_t mem_req,
  output logic                  next_addr
);

  logic [`ADDR_W-1:0] addr_q;
  logic               rrq_q;
  logic               wrq_q;
  byte                wdata_q;

  // last two samples of mcu_rq_rdy
  logic [1:0] rdy_hist;

  logic strobe;
  logic is_read;
  logic is_write;
  logic auto_inc;

  assign strobe   = evt.cmd_ready | evt.param_ready;
  assign is_read  = evt.cmd.nib.op == `OP_READ;
  assign is_write = evt.cmd.nib.op == `OP_WRITE;

  // increment only for 8x/9x with arg bit 3, once the data byte is reached
  // (byte 1 for reads, byte 2 for writes)
  assign auto_inc = (is_read | is_write) && evt.cmd.nib.arg[3] &&
                    (evt.byte_cnt >= `CNT_W'(1) + `CNT_W'(evt.cmd.nib.op[0]));

  //////////////////////////////
  // completion detect
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_hist  <= 2'b00;
      next_addr <= 1'b0;
    end else begin
      rdy_hist  <= {rdy_hist[0], mcu_rq_rdy};
      // rising edge of rdy seen in the history
      next_addr <= rdy_hist == 2'b01;
    end
  end

  //////////////////////////////
  // request pulses
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rrq_q   <= 1'b0;
      wrq_q   <= 1'b0;
      wdata_q <= '0;
    end else begin
      rrq_q <= strobe && is_read;
      wrq_q <= evt.param_ready && is_write;
      if (evt.param_ready && is_write) begin
        wdata_q <= evt.param;
      end
    end
  end

  //////////////////////////////
  // address pointer
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q <= '0;
    end else if (evt.param_ready && evt.cmd.nib.op == `OP_ADDR) begin
      case (evt.byte_cnt)
        `CNT_W'(2): begin
          // new top byte starts a fresh address
          addr_q[23:16] <= evt.param;
          addr_q[15:0]  <= '0;
        end
        `CNT_W'(3): addr_q[15:8] <= evt.param;
        `CNT_W'(4): addr_q[7:0]  <= evt.param;
        default: ;
      endcase
    end else if (next_addr && auto_inc) begin
      addr_q <= addr_q + `ADDR_W'(1);
    end
  end

  assign mem_req.addr  = addr_q;
  assign mem_req.rrq   = rrq_q;
  assign mem_req.wrq   = wrq_q;
  assign mem_req.wdata = wdata_q;

endmodule

`default_nettype wire

// File: config_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_macros.svh"

module config_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  mcu_cmd_pkg::spi_evt_t evt,
  output mcu_cmd_pkg::cfg_t     cfg
);

  // first feature byte waits here for the second
  byte feat_stage;

  // place one parameter byte into a 24-bit mask, high byte first
  function automatic logic [`ADDR_W-1:0] load_mask_byte(
    input logic [`ADDR_W-1:0] mask,
    input logic [`CNT_W-1:0]  cnt,
    input byte                data
  );
    logic [`ADDR_W-1:0] m;
    m = mask;
    case (cnt)
      `CNT_W'(2): m[23:16] = data;
      `CNT_W'(3): m[15:8]  = data;
      `CNT_W'(4): m[7:0]   = data;
      default:    m        = mask;
    endcase
    return m;
  endfunction

  //////////////////////////////
  // staging
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (evt.param_ready && evt.cmd.raw == `CMD_FEAT && evt.byte_cnt == `CNT_W'(2)) begin
      feat_stage <= evt.param;
    end
  end

  //////////////////////////////
  // config registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.mapper       <= `MAPPER_RST;
      cfg.rom_mask     <= '0;
      cfg.saveram_mask <= '0;
      cfg.featurebits  <= '0;
      cfg.region       <= 1'b0;
    end else if (evt.cmd_ready) begin
      // mapper comes straight from the command byte
      if (evt.cmd.nib.op == `OP_MAPPER) begin
        cfg.mapper <= evt.cmd.nib.arg[`MAPPER_W-1:0];
      end
    end else if (evt.param_ready) begin
      // ranged commands, decoded by nibble
      case (evt.cmd.nib.op)
        `OP_ROM_MASK:
          cfg.rom_mask <= load_mask_byte(cfg.rom_mask, evt.byte_cnt, evt.param);
        `OP_SRAM_MASK:
          cfg.saveram_mask <= load_mask_byte(cfg.saveram_mask, evt.byte_cnt, evt.param);
        default: ;
      endcase

      // Ex commands, decoded by full byte
      case (evt.cmd.raw)
        `CMD_FEAT: begin
          if (evt.byte_cnt == `CNT_W'(3)) begin
            cfg.featurebits <= {feat_stage, evt.param};
          end
        end
        `CMD_REGION:
          cfg.region <= evt.param[0];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: mcu_cmd_pkg.sv
`default_nettype none

`include "mcu_cmd_macros.svh"

package mcu_cmd_pkg;

  // command byte split into opcode and argument nibbles
  typedef struct packed {
    logic [3:0] op;
    logic [3:0] arg;
  } cmd_nib_t;

  // ranged commands decode by nibble, Ex/Fx by the whole byte
  typedef union packed {
    logic [`CMD_W-1:0] raw;
    cmd_nib_t          nib;
  } cmd_byte_u;

  // one SPI event as seen by all units
  typedef struct packed {
    logic              cmd_ready;
    logic              param_ready;
    cmd_byte_u         cmd;
    byte               param;
    logic [`CNT_W-1:0] byte_cnt;
  } spi_evt_t;

  // cartridge configuration
  typedef struct packed {
    logic [`MAPPER_W-1:0] mapper;
    logic [`ADDR_W-1:0]   rom_mask;
    logic [`ADDR_W-1:0]   saveram_mask;
    logic [`FEAT_W-1:0]   featurebits;
    logic                 region;
  } cfg_t;

  // request towards the memory arbiter
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic               rrq;
    logic               wrq;
    byte                wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// File: mcu_cmd_macros.svh
`ifndef MCU_CMD_MACROS_SVH
`define MCU_CMD_MACROS_SVH

// field widths
`define CMD_W      8
`define CNT_W      8
`define ADDR_W     24
`define MAPPER_W   3
`define FEAT_W     16

// opcode nibbles, upper half of the command byte
`define OP_ADDR       4'h0
`define OP_ROM_MASK   4'h1
`define OP_SRAM_MASK  4'h2
`define OP_MAPPER     4'h3
`define OP_READ       4'h8
`define OP_WRITE      4'h9

// full command bytes
`define CMD_FEAT      8'hED
`define CMD_REGION    8'hEE
`define CMD_ID        8'hF0
`define CMD_ECHO      8'hFF

`define ID_BYTE       8'hA5
`define MAPPER_RST    3'd1

`endif
